//--- Bender.yml
package:
  name: camera

sources:
  - include_dirs:
      - logic
    files:
      - logic/camera_pkg.sv
      - logic/camera_regs.sv
      - logic/camera_crop.sv
      - logic/camera_metering.sv
      - logic/camera.sv
  - target: test
    include_dirs:
      - logic
    files:
      - bench/camera_clock_gen.sv
      - bench/camera_assertions.sv
      - bench/camera_tb.sv

//--- bench/camera_assertions.sv
//******************************
// Bound Wishbone and cropped
// stream protocol assertions
//******************************

`timescale 1ns/1ps

module camera_assertions (
    input logic                mipi_byte_clock,
    input logic                mipi_byte_reset_n,
    input camera_pkg::wb_req_t wb_req_i,
    input camera_pkg::wb_rsp_t wb_rsp_i,
    input camera_pkg::stream_t stream_i
);

import camera_pkg::*;

int unsigned failures = 0;     // Summed by the testbench at the end
logic        req_valid;

assign req_valid = wb_req_i.cyc & wb_req_i.stb;

function automatic void note_failure(input string what);
    failures++;
    $error("%s", what);
endfunction

ack_follows_request: assert property (
    @(posedge mipi_byte_clock) disable iff (!mipi_byte_reset_n)
    req_valid && !wb_rsp_i.ack |=> wb_rsp_i.ack
) else note_failure("ack did not follow a new request by one cycle");

ack_single_cycle: assert property (
    @(posedge mipi_byte_clock) disable iff (!mipi_byte_reset_n)
    wb_rsp_i.ack |=> !wb_rsp_i.ack
) else note_failure("ack stayed high for more than one cycle");

ack_needs_cyc: assert property (
    @(posedge mipi_byte_clock) disable iff (!mipi_byte_reset_n)
    wb_rsp_i.ack |-> wb_req_i.cyc
) else note_failure("ack was raised without cyc");

// Kept pixels only inside a frame
line_inside_frame: assert property (
    @(posedge mipi_byte_clock) disable iff (!mipi_byte_reset_n)
    stream_i.line_valid |-> stream_i.frame_valid
) else note_failure("line_valid was high while frame_valid was low");

endmodule

bind camera_regs camera_assertions u_bus_checks (
    .mipi_byte_clock   (mipi_byte_clock),
    .mipi_byte_reset_n (mipi_byte_reset_n),
    .wb_req_i          (wb_req_i),
    .wb_rsp_i          (wb_rsp_o),
    .stream_i          ('0)
);

bind camera_crop camera_assertions u_stream_checks (
    .mipi_byte_clock   (mipi_byte_clock),
    .mipi_byte_reset_n (mipi_byte_reset_n),
    .wb_req_i          ('0),
    .wb_rsp_i          ('0),
    .stream_i          (pixel_o)
);

//--- bench/camera_clock_gen.sv
//******************************
// Testbench clock and reset
//******************************

`timescale 1ns/1ps

module camera_clock_gen (
    output logic mipi_byte_clock_o,
    output logic mipi_byte_reset_n_o
);

initial begin
    mipi_byte_clock_o = 1'b0;
    forever #10 mipi_byte_clock_o = ~mipi_byte_clock_o;     // 20 ns period
end

initial begin
    mipi_byte_reset_n_o = 1'b0;
    repeat (5) @(posedge mipi_byte_clock_o);
    @(negedge mipi_byte_clock_o);     // Release away from the active edge
    mipi_byte_reset_n_o = 1'b1;
end

endmodule

//--- bench/camera_tb.sv
//******************************
// Testbench: random frames and
// bus traffic against a model
//******************************

`timescale 1ns/1ps
`include "camera_defines.svh"

module camera_tb;

import camera_pkg::*;

localparam int FRAME_W      = 16;
localparam int FRAME_H      = 12;
localparam int LINE_BLANK   = 4;
localparam int FRAME_BLANK  = 8;
localparam int FRAME_CYCLES = FRAME_H * (FRAME_W + LINE_BLANK) + FRAME_BLANK;
localparam int NUM_FRAMES   = 7;
localparam int NUM_ACCESSES = 110;
localparam int CYCLE_LIMIT  = NUM_FRAMES * FRAME_CYCLES + NUM_ACCESSES * 50 + 1000;

logic         mipi_byte_clock;
logic         mipi_byte_reset_n;
wb_req_t      wb_req;
wb_rsp_t      wb_rsp;
stream_t      pixel_in;
stream_t      pixel_out;
integer       seed = 32'hd53ec2f6;
int           cycle_count = 0;
int           frames_sent = 0;
int           lv_seen = 0;
string        test_name = "reset values";
crop_window_t win_model;
logic         meter_en_model;
sum_t         sum_model [3];     // Red, green, blue
metering_t    meter_model;

camera_clock_gen u_clock_gen (
    .mipi_byte_clock_o   (mipi_byte_clock),
    .mipi_byte_reset_n_o (mipi_byte_reset_n)
);

camera u_camera (
    .mipi_byte_clock   (mipi_byte_clock),
    .mipi_byte_reset_n (mipi_byte_reset_n),
    .wb_req_i          (wb_req),
    .wb_rsp_o          (wb_rsp),
    .pixel_i           (pixel_in),
    .pixel_o           (pixel_out)
);

task automatic fail_run(input string reason);
    $display("%s", reason);
    $display("RESULT: FAIL");
    $fatal(1, "Run stopped at the first error");
endtask

always @(posedge mipi_byte_clock) begin
    cycle_count++;
    if (cycle_count >= CYCLE_LIMIT) begin
        fail_run("Timeout: the tests did not finish within the cycle limit");
    end
end

task automatic check_word(input string what, input wb_data_t expected, input wb_data_t actual);
    if (actual !== expected) begin
        fail_run($sformatf("ERROR: %s %s: expected %h, actual %h",
                           test_name, what, expected, actual));
    end
endtask

task automatic check_metering(input string what, input metering_t expected,
                              input metering_t actual);
    if (actual !== expected) begin
        fail_run($sformatf("ERROR: %s %s: expected %p, actual %p",
                           test_name, what, expected, actual));
    end
endtask

// Data and phase only count on kept pixels
task automatic check_stream(input string what, input stream_t expected, input stream_t actual);
    if (actual.line_valid !== expected.line_valid ||
        actual.frame_valid !== expected.frame_valid ||
        (expected.line_valid && actual !== expected)) begin
        fail_run($sformatf("ERROR: %s %s: expected %h, actual %h",
                           test_name, what, expected, actual));
    end
endtask

task automatic bus_access(input logic we, input wb_addr_t adr, input wb_data_t wdata,
                          output wb_data_t rdata);
    wb_req = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: wdata};
    do begin
        @(negedge mipi_byte_clock);
    end while (!wb_rsp.ack);
    rdata  = wb_rsp.dat;
    @(negedge mipi_byte_clock);     // Hold through the ack cycle
    wb_req = '0;
    @(negedge mipi_byte_clock);
endtask

// Expected read value of every word in the map
function automatic wb_data_t reg_model(input wb_addr_t adr);
    case (adr)
        `CAM_REG_CTRL:    return wb_data_t'(meter_en_model);
        `CAM_REG_X_START: return wb_data_t'(win_model.x_start);
        `CAM_REG_X_END:   return wb_data_t'(win_model.x_end);
        `CAM_REG_Y_START: return wb_data_t'(win_model.y_start);
        `CAM_REG_Y_END:   return wb_data_t'(win_model.y_end);
        `CAM_REG_RED:     return wb_data_t'(meter_model.red_sum);
        `CAM_REG_GREEN:   return wb_data_t'(meter_model.green_sum);
        `CAM_REG_BLUE:    return wb_data_t'(meter_model.blue_sum);
        `CAM_REG_FRAMES:  return wb_data_t'(meter_model.frame_count);
        default:          return '0;
    endcase
endfunction

task automatic write_reg(input wb_addr_t adr, input wb_data_t data);
    wb_data_t unused;
    bus_access(1'b1, adr, data, unused);
    case (adr)
        `CAM_REG_CTRL:    meter_en_model = data[`CAM_CTRL_METER_EN_BIT];
        `CAM_REG_X_START: win_model.x_start = data[`CAM_COORD_WIDTH-1:0];
        `CAM_REG_X_END:   win_model.x_end = data[`CAM_COORD_WIDTH-1:0];
        `CAM_REG_Y_START: win_model.y_start = data[`CAM_COORD_WIDTH-1:0];
        `CAM_REG_Y_END:   win_model.y_end = data[`CAM_COORD_WIDTH-1:0];
        default:          ;     // Unmapped or read only
    endcase
endtask

task automatic read_check(input wb_addr_t adr);
    wb_data_t data;
    bus_access(1'b0, adr, '0, data);
    check_word($sformatf("register %0d", adr), reg_model(adr), data);
endtask

task automatic read_metering();
    wb_data_t  data;
    metering_t actual;
    bus_access(1'b0, `CAM_REG_RED, '0, data);
    actual.red_sum = data[`CAM_SUM_WIDTH-1:0];
    bus_access(1'b0, `CAM_REG_GREEN, '0, data);
    actual.green_sum = data[`CAM_SUM_WIDTH-1:0];
    bus_access(1'b0, `CAM_REG_BLUE, '0, data);
    actual.blue_sum = data[`CAM_SUM_WIDTH-1:0];
    bus_access(1'b0, `CAM_REG_FRAMES, '0, data);
    actual.frame_count = data[`CAM_FRAME_COUNT_WIDTH-1:0];
    check_metering("metering results", meter_model, actual);
endtask

// One input cycle, checked one cycle later
task automatic drive_cycle(input logic lv, input logic fv, input int row, input int col);
    stream_t expected;
    logic    keep;
    keep = lv && fv && col >= win_model.x_start && col < win_model.x_end &&
           row >= win_model.y_start && row < win_model.y_end;
    pixel_in = '{data: pixel_t'($random(seed)), line_valid: lv, frame_valid: fv,
                 row_odd: 1'b0, col_odd: 1'b0};
    expected = '{data: pixel_in.data, line_valid: keep, frame_valid: fv,
                 row_odd: row[0], col_odd: col[0]};
    @(negedge mipi_byte_clock);
    check_stream("pixel_o", expected, pixel_out);
    if (pixel_out.line_valid) begin
        lv_seen++;
    end
    if (keep && meter_en_model) begin
        sum_model[row % 2 + col % 2] += sum_t'(expected.data);     // RGGB channel index
    end
endtask

task automatic send_frame();
    lv_seen = 0;
    for (int r = 0; r < FRAME_H; r++) begin
        for (int c = 0; c < FRAME_W; c++) begin
            drive_cycle(1'b1, 1'b1, r, c);
        end
        repeat (LINE_BLANK) drive_cycle(1'b0, 1'b1, r, FRAME_W);
    end
    repeat (FRAME_BLANK) drive_cycle(1'b0, 1'b0, 0, 0);
    frames_sent++;
    meter_model = '{red_sum: sum_model[0], green_sum: sum_model[1],
                    blue_sum: sum_model[2], frame_count: frames_sent[7:0]};
    sum_model = '{default: '0};
endtask

task automatic random_window();
    int xs;
    int ys;
    xs = $unsigned($random(seed)) % FRAME_W;
    ys = $unsigned($random(seed)) % FRAME_H;
    write_reg(`CAM_REG_X_START, xs);
    write_reg(`CAM_REG_X_END, xs + 1 + $unsigned($random(seed)) % (FRAME_W + 1 - xs));
    write_reg(`CAM_REG_Y_START, ys);
    write_reg(`CAM_REG_Y_END, ys + 1 + $unsigned($random(seed)) % (FRAME_H + 1 - ys));
endtask

initial begin
    int assert_failures;
    wb_req         = '0;
    pixel_in       = '0;
    win_model      = '{x_start: `CAM_WINDOW_START_RESET, x_end: `CAM_WINDOW_END_RESET,
                       y_start: `CAM_WINDOW_START_RESET, y_end: `CAM_WINDOW_END_RESET};
    meter_en_model = 1'b0;
    meter_model    = '0;
    sum_model      = '{default: '0};
    @(posedge mipi_byte_reset_n);
    @(negedge mipi_byte_clock);

    for (int a = 0; a < 16; a++) begin
        read_check(wb_addr_t'(a));     // Unmapped words expect zero
    end

    test_name = "window readback";
    write_reg(`CAM_REG_X_START, $random(seed));
    write_reg(`CAM_REG_X_END, $random(seed));
    write_reg(`CAM_REG_Y_START, $random(seed));
    write_reg(`CAM_REG_Y_END, $random(seed));
    write_reg(4'hb, $random(seed));
    for (int a = 0; a < 16; a++) begin
        read_check(wb_addr_t'(a));
    end

    test_name = "crop and metering";
    write_reg(`CAM_REG_CTRL, 32'h1);
    for (int f = 0; f < 5; f++) begin
        random_window();
        send_frame();
        read_metering();
    end

    test_name = "metering disabled";
    write_reg(`CAM_REG_CTRL, 32'h0);
    random_window();
    send_frame();
    read_metering();

    test_name = "empty window";
    write_reg(`CAM_REG_CTRL, 32'h1);
    write_reg(`CAM_REG_X_START, 32'd5);
    write_reg(`CAM_REG_X_END, 32'd5);
    send_frame();
    read_metering();
    check_word("line_valid count", '0, lv_seen);

    assert_failures = u_camera.u_regs.u_bus_checks.failures +
                      u_camera.u_crop.u_stream_checks.failures;
    if (assert_failures == 0) begin
        $display("RESULT: PASS");
        $finish;
    end else begin
        fail_run("Concurrent assertions reported protocol errors");
    end
end

endmodule

//--- logic/camera.sv
//******************************
// Camera front top level
//******************************

`timescale 1ns/1ps

module camera (
    input  logic                mipi_byte_clock,
    input  logic                mipi_byte_reset_n,
    input  camera_pkg::wb_req_t wb_req_i,
    output camera_pkg::wb_rsp_t wb_rsp_o,
    input  camera_pkg::stream_t pixel_i,
    output camera_pkg::stream_t pixel_o
);

import camera_pkg::*;

crop_window_t window;
logic         meter_enable;
metering_t    metering;

camera_regs u_regs (
    .mipi_byte_clock   (mipi_byte_clock),
    .mipi_byte_reset_n (mipi_byte_reset_n),
    .wb_req_i          (wb_req_i),
    .wb_rsp_o          (wb_rsp_o),
    .window_o          (window),
    .meter_enable_o    (meter_enable),
    .metering_i        (metering)
);

camera_crop u_crop (
    .mipi_byte_clock   (mipi_byte_clock),
    .mipi_byte_reset_n (mipi_byte_reset_n),
    .window_i          (window),
    .pixel_i           (pixel_i),
    .pixel_o           (pixel_o)      // Also feeds metering
);

camera_metering u_metering (
    .mipi_byte_clock   (mipi_byte_clock),
    .mipi_byte_reset_n (mipi_byte_reset_n),
    .meter_enable_i    (meter_enable),
    .pixel_i           (pixel_o),
    .metering_o        (metering)
);

endmodule

//--- logic/camera_crop.sv
//******************************
// Window crop with pixel
// coordinates and Bayer phase
//******************************

`timescale 1ns/1ps

module camera_crop (
    input  logic                     mipi_byte_clock,
    input  logic                     mipi_byte_reset_n,
    input  camera_pkg::crop_window_t window_i,
    input  camera_pkg::stream_t      pixel_i,
    output camera_pkg::stream_t      pixel_o
);

import camera_pkg::*;

logic   line_valid_q;
logic   frame_valid_q;
logic   line_start;
logic   line_end;
logic   frame_start;
logic   in_window;
logic   keep;
coord_t col_count;
coord_t row_count;
coord_t column;
coord_t row;

assign line_start  = pixel_i.line_valid & ~line_valid_q;
assign line_end    = ~pixel_i.line_valid & line_valid_q;
assign frame_start = pixel_i.frame_valid & ~frame_valid_q;

// Coordinates of the pixel on the input this cycle
assign column = line_start ? '0 : col_count;
assign row    = frame_start ? '0 : row_count;

assign in_window = (column >= window_i.x_start) && (column < window_i.x_end) &&
                   (row >= window_i.y_start) && (row < window_i.y_end);

assign keep = pixel_i.line_valid & pixel_i.frame_valid & in_window;

always_ff @(posedge mipi_byte_clock or negedge mipi_byte_reset_n) begin
    if (!mipi_byte_reset_n) begin
        line_valid_q  <= 1'b0;
        frame_valid_q <= 1'b0;
        col_count     <= '0;
        row_count     <= '0;
    end else begin
        line_valid_q  <= pixel_i.line_valid;
        frame_valid_q <= pixel_i.frame_valid;
        if (pixel_i.line_valid) begin
            col_count <= column + 1'b1;
        end
        if (frame_start) begin
            row_count <= '0;
        end else if (line_end) begin
            row_count <= row_count + 1'b1;     // Next line of the frame
        end
    end
end

// One cycle stage for every stream field
always_ff @(posedge mipi_byte_clock or negedge mipi_byte_reset_n) begin
    if (!mipi_byte_reset_n) begin
        pixel_o <= '0;
    end else begin
        pixel_o.data        <= keep ? pixel_i.data : '0;
        pixel_o.line_valid  <= keep;
        pixel_o.frame_valid <= pixel_i.frame_valid;
        pixel_o.row_odd     <= row[0];     // Absolute parity
        pixel_o.col_odd     <= column[0];
    end
end

endmodule

//--- logic/camera_defines.svh
//******************************
// Field widths, register word
// addresses and reset values
//******************************

`ifndef CAMERA_DEFINES_SVH
`define CAMERA_DEFINES_SVH

`define CAM_PIXEL_WIDTH         10
`define CAM_COORD_WIDTH         12
`define CAM_SUM_WIDTH           24
`define CAM_WB_DATA_WIDTH       32
`define CAM_WB_ADDR_WIDTH       4
`define CAM_FRAME_COUNT_WIDTH   8

`define CAM_REG_CTRL            4'd0
`define CAM_REG_X_START         4'd1
`define CAM_REG_X_END           4'd2
`define CAM_REG_Y_START         4'd3
`define CAM_REG_Y_END           4'd4
`define CAM_REG_RED             4'd5
`define CAM_REG_GREEN           4'd6
`define CAM_REG_BLUE            4'd7
`define CAM_REG_FRAMES          4'd8

`define CAM_WINDOW_START_RESET  12'd0
`define CAM_WINDOW_END_RESET    12'd4095
`define CAM_CTRL_METER_EN_BIT   0

`endif

//--- logic/camera_metering.sv
//******************************
// Per-channel RGGB sums over a
// frame, latched at frame end
//******************************

`timescale 1ns/1ps

module camera_metering (
    input  logic                  mipi_byte_clock,
    input  logic                  mipi_byte_reset_n,
    input  logic                  meter_enable_i,
    input  camera_pkg::stream_t   pixel_i,
    output camera_pkg::metering_t metering_o
);

import camera_pkg::*;

logic frame_valid_q;
logic frame_end;
logic accumulate;
logic is_red;
logic is_green;
logic is_blue;
sum_t pixel_ext;
sum_t red_acc;
sum_t green_acc;
sum_t blue_acc;

assign frame_end  = frame_valid_q & ~pixel_i.frame_valid;
assign accumulate = meter_enable_i & pixel_i.line_valid;

// RGGB phase decode
assign is_red   = ~pixel_i.row_odd & ~pixel_i.col_odd;
assign is_blue  = pixel_i.row_odd & pixel_i.col_odd;
assign is_green = pixel_i.row_odd ^ pixel_i.col_odd;

assign pixel_ext = sum_t'(pixel_i.data);

always_ff @(posedge mipi_byte_clock or negedge mipi_byte_reset_n) begin
    if (!mipi_byte_reset_n) begin
        frame_valid_q <= 1'b0;
    end else begin
        frame_valid_q <= pixel_i.frame_valid;
    end
end

always_ff @(posedge mipi_byte_clock or negedge mipi_byte_reset_n) begin
    if (!mipi_byte_reset_n) begin
        red_acc   <= '0;
        green_acc <= '0;
        blue_acc  <= '0;
    end else if (frame_end) begin
        red_acc   <= '0;     // Start over for the next frame
        green_acc <= '0;
        blue_acc  <= '0;
    end else if (accumulate) begin
        if (is_red) begin
            red_acc <= red_acc + pixel_ext;
        end
        if (is_green) begin
            green_acc <= green_acc + pixel_ext;
        end
        if (is_blue) begin
            blue_acc <= blue_acc + pixel_ext;
        end
    end
end

// Results hold until the next frame ends
always_ff @(posedge mipi_byte_clock or negedge mipi_byte_reset_n) begin
    if (!mipi_byte_reset_n) begin
        metering_o <= '0;
    end else if (frame_end) begin
        metering_o.red_sum     <= red_acc;
        metering_o.green_sum   <= green_acc;
        metering_o.blue_sum    <= blue_acc;
        metering_o.frame_count <= metering_o.frame_count + 1'b1;     // Wraps at 255
    end
end

endmodule

//--- logic/camera_pkg.sv
//******************************
// Vector types and structs for
// stream, bus, window, metering
//******************************

`include "camera_defines.svh"

package camera_pkg;

typedef logic [`CAM_PIXEL_WIDTH-1:0]       pixel_t;
typedef logic [`CAM_COORD_WIDTH-1:0]       coord_t;
typedef logic [`CAM_SUM_WIDTH-1:0]         sum_t;
typedef logic [`CAM_WB_DATA_WIDTH-1:0]     wb_data_t;
typedef logic [`CAM_WB_ADDR_WIDTH-1:0]     wb_addr_t;
typedef logic [`CAM_FRAME_COUNT_WIDTH-1:0] frame_count_t;

typedef struct packed {
    pixel_t data;
    logic   line_valid;
    logic   frame_valid;
    logic   row_odd;      // Bayer phase, crop output only
    logic   col_odd;
} stream_t;

typedef struct packed {
    logic     cyc;
    logic     stb;
    logic     we;
    wb_addr_t adr;
    wb_data_t dat;
} wb_req_t;

typedef struct packed {
    logic     ack;
    wb_data_t dat;
} wb_rsp_t;

typedef struct packed {
    coord_t x_start;
    coord_t x_end;      // Exclusive
    coord_t y_start;
    coord_t y_end;      // Exclusive
} crop_window_t;

typedef struct packed {
    sum_t         red_sum;
    sum_t         green_sum;
    sum_t         blue_sum;
    frame_count_t frame_count;
} metering_t;

endpackage

//--- logic/camera_regs.sv
//******************************
// Wishbone classic register
// block: control, crop window
// and metering readback
//******************************

`timescale 1ns/1ps
`include "camera_defines.svh"

module camera_regs (
    input  logic                     mipi_byte_clock,
    input  logic                     mipi_byte_reset_n,
    input  camera_pkg::wb_req_t      wb_req_i,
    output camera_pkg::wb_rsp_t      wb_rsp_o,
    output camera_pkg::crop_window_t window_o,
    output logic                     meter_enable_o,
    input  camera_pkg::metering_t    metering_i
);

import camera_pkg::*;

logic     req_valid;
logic     access;
logic     write_en;
logic     ack_q;
wb_data_t dat_q;
wb_data_t read_data;

assign req_valid = wb_req_i.cyc & wb_req_i.stb;
assign access    = req_valid & ~ack_q;      // First cycle of a request
assign write_en  = access & wb_req_i.we;

assign wb_rsp_o = '{ack: ack_q, dat: dat_q};

// Read mux, unmapped words return zero
always_comb begin
    read_data = '0;
    case (wb_req_i.adr)
        `CAM_REG_CTRL:    read_data[`CAM_CTRL_METER_EN_BIT] = meter_enable_o;
        `CAM_REG_X_START: read_data = wb_data_t'(window_o.x_start);
        `CAM_REG_X_END:   read_data = wb_data_t'(window_o.x_end);
        `CAM_REG_Y_START: read_data = wb_data_t'(window_o.y_start);
        `CAM_REG_Y_END:   read_data = wb_data_t'(window_o.y_end);
        `CAM_REG_RED:     read_data = wb_data_t'(metering_i.red_sum);
        `CAM_REG_GREEN:   read_data = wb_data_t'(metering_i.green_sum);
        `CAM_REG_BLUE:    read_data = wb_data_t'(metering_i.blue_sum);
        `CAM_REG_FRAMES:  read_data = wb_data_t'(metering_i.frame_count);
        default:          read_data = '0;
    endcase
end

// Single cycle ack, one cycle after the request starts
always_ff @(posedge mipi_byte_clock or negedge mipi_byte_reset_n) begin
    if (!mipi_byte_reset_n) begin
        ack_q <= 1'b0;
    end else begin
        ack_q <= access;
    end
end

always_ff @(posedge mipi_byte_clock) begin
    if (access) begin
        dat_q <= read_data;     // Valid together with ack
    end
end

// Writes land on the same edge that raises ack
always_ff @(posedge mipi_byte_clock or negedge mipi_byte_reset_n) begin
    if (!mipi_byte_reset_n) begin
        meter_enable_o   <= 1'b0;
        window_o.x_start <= `CAM_WINDOW_START_RESET;
        window_o.x_end   <= `CAM_WINDOW_END_RESET;
        window_o.y_start <= `CAM_WINDOW_START_RESET;
        window_o.y_end   <= `CAM_WINDOW_END_RESET;
    end else if (write_en) begin
        case (wb_req_i.adr)
            `CAM_REG_CTRL: begin
                meter_enable_o <= wb_req_i.dat[`CAM_CTRL_METER_EN_BIT];
            end
            `CAM_REG_X_START: begin
                window_o.x_start <= wb_req_i.dat[`CAM_COORD_WIDTH-1:0];
            end
            `CAM_REG_X_END: begin
                window_o.x_end <= wb_req_i.dat[`CAM_COORD_WIDTH-1:0];
            end
            `CAM_REG_Y_START: begin
                window_o.y_start <= wb_req_i.dat[`CAM_COORD_WIDTH-1:0];
            end
            `CAM_REG_Y_END: begin
                window_o.y_end <= wb_req_i.dat[`CAM_COORD_WIDTH-1:0];
            end
            default: begin
                // Metering words are read only
            end
        endcase
    end
end

endmodule

//--- src.f
+incdir+logic
logic/camera_pkg.sv
logic/camera_regs.sv
logic/camera_crop.sv
logic/camera_metering.sv
logic/camera.sv
bench/camera_clock_gen.sv
bench/camera_assertions.sv
bench/camera_tb.sv
